// ==== hdl/gpu_consts.svh ====
`ifndef GPU_CONSTS_SVH
`define GPU_CONSTS_SVH

// framebuffer geometry in pixels
`define GPU_FB_W 32
`define GPU_FB_H 16

// total pixel count, width times height
`define GPU_FB_PIXELS 512

// entries in the host command FIFO
`define GPU_FIFO_DEPTH 4

// far plane depth
`define GPU_CLEAR_Z 8'hff

// black background
`define GPU_CLEAR_RGB 12'h000

`endif

// ==== hdl/gpu_pkg.sv ====
package gpu_pkg;

  // screen space coordinates
  typedef logic [4:0] coord_x_t;
  typedef logic [3:0] coord_y_t;

  // smaller depth is nearer to the viewer
  typedef logic [7:0] depth_t;

  // 4 bits per channel, r in the top nibble
  typedef logic [11:0] rgb_t;

  // linear pixel address, row times width plus column
  typedef logic [8:0] fb_addr_t;

  // frame and pixel counters
  typedef logic [15:0] count_t;

  // rectangle command, msb first
  //   [37:33] x0  [32:29] y0  [28:24] x1  [23:20] y1
  //   [19:12] z   [11:0]  rgb
  // corners are inclusive, x1 < x0 or y1 < y0 draws nothing
  typedef logic [37:0] rect_cmd_t;

  // frame control
  typedef enum logic [1:0] {
    seq_clear,
    seq_draw,
    seq_drain,
    seq_idle
  } frame_state_t;

endpackage

// ==== hdl/rect_fifo.sv ====
`timescale 1ns/1ps
`include "gpu_consts.svh"

module rect_fifo (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               push_valid,
  output logic               push_ready,
  input  gpu_pkg::rect_cmd_t push_data,
  output logic               pop_valid,
  input  logic               pop_ready,
  output gpu_pkg::rect_cmd_t pop_data,
  output logic               empty
);
  import gpu_pkg::*;

  localparam int ptr_w = $clog2(`GPU_FIFO_DEPTH);
  localparam int cnt_w = ptr_w + 1;

  rect_cmd_t        mem [`GPU_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] count_next;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(`GPU_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign do_push   = push_valid && push_ready;
  assign do_pop    = pop_valid && pop_ready;
  assign pop_valid = (count != '0);
  assign empty     = (count == '0);
  assign pop_data  = mem[rd_ptr];

  always_comb begin
    case ({do_push, do_pop})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  // ready is registered so it stays low through reset
  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      push_ready <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count      <= count_next;
      push_ready <= (count_next != cnt_w'(`GPU_FIFO_DEPTH));
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// ==== hdl/rect_raster.sv ====
`timescale 1ns/1ps

module rect_raster (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               draw_en,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  gpu_pkg::rect_cmd_t cmd_data,
  output logic               idle,
  output logic               frag_valid,
  output gpu_pkg::coord_x_t  frag_x,
  output gpu_pkg::coord_y_t  frag_y,
  output gpu_pkg::depth_t    frag_z,
  output gpu_pkg::rgb_t      frag_rgb
);
  import gpu_pkg::*;

  // command fields
  coord_x_t c_x0;
  coord_y_t c_y0;
  coord_x_t c_x1;
  coord_y_t c_y1;
  depth_t   c_z;
  rgb_t     c_rgb;

  assign c_x0  = cmd_data[37:33];
  assign c_y0  = cmd_data[32:29];
  assign c_x1  = cmd_data[28:24];
  assign c_y1  = cmd_data[23:20];
  assign c_z   = cmd_data[19:12];
  assign c_rgb = cmd_data[11:0];

  logic     active;
  logic     load;
  logic     last_col;
  logic     last_row;
  coord_x_t cur_x;
  coord_y_t cur_y;
  coord_x_t x_start;
  coord_x_t x_end;
  coord_y_t y_end;
  depth_t   z_q;
  rgb_t     rgb_q;

  assign cmd_ready = !active && draw_en;
  assign load      = cmd_valid && cmd_ready;
  assign last_col  = (cur_x == x_end);
  assign last_row  = (cur_y == y_end);

  // idle only once the last fragment has left the output register
  assign idle = !active && !frag_valid;

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      active     <= 1'b0;
      frag_valid <= 1'b0;
    end else begin
      frag_valid <= active;
      if (load) begin
        // empty rectangles never start a walk
        active <= (c_x1 >= c_x0) && (c_y1 >= c_y0);
      end else if (active && last_col && last_row) begin
        active <= 1'b0;
      end
    end
  end

  always_ff @(posedge gpu_clk) begin
    if (load) begin
      x_start <= c_x0;
      x_end   <= c_x1;
      y_end   <= c_y1;
      z_q     <= c_z;
      rgb_q   <= c_rgb;
      cur_x   <= c_x0;
      cur_y   <= c_y0;
    end else if (active) begin
      // row major walk
      if (last_col) begin
        cur_x <= x_start;
        cur_y <= cur_y + 1'b1;
      end else begin
        cur_x <= cur_x + 1'b1;
      end
    end
  end

  always_ff @(posedge gpu_clk) begin
    frag_x   <= cur_x;
    frag_y   <= cur_y;
    frag_z   <= z_q;
    frag_rgb <= rgb_q;
  end

endmodule

// ==== hdl/depth_framebuffer.sv ====
`timescale 1ns/1ps
`include "gpu_consts.svh"

module depth_framebuffer (
  input  logic              gpu_clk,
  input  logic              rst_in,
  input  logic              clear_start,
  output logic              clear_done,
  input  logic              frag_valid,
  input  gpu_pkg::coord_x_t frag_x,
  input  gpu_pkg::coord_y_t frag_y,
  input  gpu_pkg::depth_t   frag_z,
  input  gpu_pkg::rgb_t     frag_rgb,
  output logic              pix_written,
  input  logic              rd_en,
  input  gpu_pkg::coord_x_t rd_x,
  input  gpu_pkg::coord_y_t rd_y,
  output logic              rd_valid,
  output gpu_pkg::rgb_t     rd_rgb
);
  import gpu_pkg::*;

  localparam fb_addr_t last_addr = fb_addr_t'(`GPU_FB_PIXELS - 1);

  rgb_t   color_mem [`GPU_FB_PIXELS];
  depth_t depth_mem [`GPU_FB_PIXELS];

  logic     clearing;
  fb_addr_t clr_addr;

  // stage 1 holds the fragment while its depth is read
  logic     s1_valid;
  fb_addr_t s1_addr;
  depth_t   s1_z;
  rgb_t     s1_rgb;
  depth_t   s1_stored;

  // last depth write, for back to back hits on one address
  logic     fwd_valid;
  fb_addr_t fwd_addr;
  depth_t   fwd_z;

  depth_t   cur_z;
  logic     frag_we;
  fb_addr_t frag_addr;
  fb_addr_t rd_addr;

  function automatic fb_addr_t pix_addr(input coord_x_t x, input coord_y_t y);
    return fb_addr_t'(y) * fb_addr_t'(`GPU_FB_W) + fb_addr_t'(x);
  endfunction

  assign frag_addr = pix_addr(frag_x, frag_y);
  assign rd_addr   = pix_addr(rd_x, rd_y);

  assign cur_z = (fwd_valid && (fwd_addr == s1_addr)) ? fwd_z : s1_stored;

  // strictly nearer wins, ties keep the earlier fragment
  assign frag_we     = s1_valid && !clearing && (s1_z < cur_z);
  assign pix_written = frag_we;
  assign clear_done  = clearing && (clr_addr == last_addr);

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      clearing  <= 1'b0;
      clr_addr  <= '0;
      s1_valid  <= 1'b0;
      fwd_valid <= 1'b0;
      rd_valid  <= 1'b0;
    end else begin
      s1_valid  <= frag_valid;
      fwd_valid <= frag_we;
      rd_valid  <= rd_en;
      if (clear_start) begin
        clearing <= 1'b1;
        clr_addr <= '0;
      end else if (clearing) begin
        if (clr_addr == last_addr) begin
          clearing <= 1'b0;
        end
        clr_addr <= clr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge gpu_clk) begin
    s1_addr   <= frag_addr;
    s1_z      <= frag_z;
    s1_rgb    <= frag_rgb;
    s1_stored <= depth_mem[frag_addr];
    fwd_addr  <= s1_addr;
    fwd_z     <= s1_z;
    rd_rgb    <= color_mem[rd_addr];
  end

  // one write port per memory, clear sweep first
  always_ff @(posedge gpu_clk) begin
    if (clearing) begin
      color_mem[clr_addr] <= `GPU_CLEAR_RGB;
      depth_mem[clr_addr] <= `GPU_CLEAR_Z;
    end else if (frag_we) begin
      color_mem[s1_addr] <= s1_rgb;
      depth_mem[s1_addr] <= s1_z;
    end
  end

endmodule

// ==== hdl/frame_sequencer.sv ====
`timescale 1ns/1ps

module frame_sequencer (
  input  logic            gpu_clk,
  input  logic            rst_in,
  input  logic            frame_start,
  input  logic            frame_end,
  output logic            clear_start,
  input  logic            clear_done,
  output logic            draw_en,
  input  logic            fifo_empty,
  input  logic            raster_idle,
  input  logic            pix_written,
  output logic            busy,
  output gpu_pkg::count_t frame_count,
  output gpu_pkg::count_t last_pixel_count
);
  import gpu_pkg::*;

  frame_state_t state;
  count_t       pixel_count;
  logic         end_seen;

  always_ff @(posedge gpu_clk) begin
    if (rst_in) begin
      state            <= seq_idle;
      busy             <= 1'b0;
      draw_en          <= 1'b0;
      clear_start      <= 1'b0;
      end_seen         <= 1'b0;
      pixel_count      <= '0;
      frame_count      <= '0;
      last_pixel_count <= '0;
    end else begin
      clear_start <= 1'b0;
      case (state)
        seq_idle: begin
          if (frame_start) begin
            busy        <= 1'b1;
            clear_start <= 1'b1;
            end_seen    <= 1'b0;
            state       <= seq_clear;
          end
        end
        seq_clear: begin
          // an early frame_end is held until drawing starts
          if (frame_end) begin
            end_seen <= 1'b1;
          end
          if (clear_done) begin
            draw_en     <= 1'b1;
            pixel_count <= '0;
            state       <= seq_draw;
          end
        end
        seq_draw: begin
          pixel_count <= pixel_count + count_t'(pix_written);
          if (frame_end || end_seen) begin
            state <= seq_drain;
          end
        end
        seq_drain: begin
          pixel_count <= pixel_count + count_t'(pix_written);
          if (fifo_empty && raster_idle) begin
            // the final fragment's write lands in this same cycle
            last_pixel_count <= pixel_count + count_t'(pix_written);
            frame_count      <= frame_count + 1'b1;
            draw_en          <= 1'b0;
            busy             <= 1'b0;
            state            <= seq_idle;
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

endmodule

// ==== hdl/gpu_top.sv ====
`timescale 1ns/1ps

module gpu_top (
  input  logic               gpu_clk,
  input  logic               rst_in,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  input  gpu_pkg::rect_cmd_t cmd_data,
  input  logic               frame_start,
  input  logic               frame_end,
  input  logic               rd_en,
  input  gpu_pkg::coord_x_t  rd_x,
  input  gpu_pkg::coord_y_t  rd_y,
  output logic               rd_valid,
  output gpu_pkg::rgb_t      rd_rgb,
  output logic               busy,
  output gpu_pkg::count_t    frame_count,
  output gpu_pkg::count_t    last_pixel_count
);
  import gpu_pkg::*;

  // fifo to rasterizer
  logic      pop_valid;
  logic      pop_ready;
  rect_cmd_t pop_data;
  logic      fifo_empty;

  // rasterizer to framebuffer
  logic      raster_idle;
  logic      frag_valid;
  coord_x_t  frag_x;
  coord_y_t  frag_y;
  depth_t    frag_z;
  rgb_t      frag_rgb;

  // frame control
  logic      pix_written;
  logic      clear_start;
  logic      clear_done;
  logic      draw_en;

  rect_fifo rect_fifo (
    .gpu_clk,
    .rst_in,
    .push_valid(cmd_valid),
    .push_ready(cmd_ready),
    .push_data(cmd_data),
    .pop_valid,
    .pop_ready,
    .pop_data,
    .empty(fifo_empty)
  );

  rect_raster rect_raster (
    .gpu_clk,
    .rst_in,
    .draw_en,
    .cmd_valid(pop_valid),
    .cmd_ready(pop_ready),
    .cmd_data(pop_data),
    .idle(raster_idle),
    .frag_valid,
    .frag_x,
    .frag_y,
    .frag_z,
    .frag_rgb
  );

  depth_framebuffer depth_framebuffer (
    .gpu_clk,
    .rst_in,
    .clear_start,
    .clear_done,
    .frag_valid,
    .frag_x,
    .frag_y,
    .frag_z,
    .frag_rgb,
    .pix_written,
    .rd_en,
    .rd_x,
    .rd_y,
    .rd_valid,
    .rd_rgb
  );

  frame_sequencer frame_sequencer (
    .gpu_clk,
    .rst_in,
    .frame_start,
    .frame_end,
    .clear_start,
    .clear_done,
    .draw_en,
    .fifo_empty,
    .raster_idle,
    .pix_written,
    .busy,
    .frame_count,
    .last_pixel_count
  );

endmodule

// ==== sim/gpu_asserts.sv ====
`timescale 1ns/1ps

module gpu_asserts (
  input logic               gpu_clk,
  input logic               rst_in,
  input logic               cmd_valid,
  input logic               cmd_ready,
  input gpu_pkg::rect_cmd_t cmd_data,
  input logic               rd_en,
  input logic               rd_valid,
  input logic               busy
);
  import gpu_pkg::*;

  int fail_count = 0;

  // host holds a stalled command
  cmd_hold: assert property (@(posedge gpu_clk) disable iff (rst_in)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
  else begin
    fail_count++;
    $error("cmd_data or cmd_valid changed while cmd_ready was low");
  end

  // readback answers exactly one cycle later
  rd_latency: assert property (@(posedge gpu_clk) disable iff (rst_in)
    rd_valid == $past(rd_en))
  else begin
    fail_count++;
    $error("rd_valid does not follow rd_en by one cycle");
  end

  busy_reset: assert property (@(posedge gpu_clk) rst_in |=> !busy)
  else begin
    fail_count++;
    $error("busy is high right after reset");
  end

endmodule

bind gpu_top gpu_asserts gpu_asserts0 (
  .gpu_clk(gpu_clk),
  .rst_in(rst_in),
  .cmd_valid(cmd_valid),
  .cmd_ready(cmd_ready),
  .cmd_data(cmd_data),
  .rd_en(rd_en),
  .rd_valid(rd_valid),
  .busy(busy)
);

// ==== sim/gpu_tb.sv ====
`timescale 1ns/1ps
`include "gpu_consts.svh"

module gpu_tb;
  import gpu_pkg::*;

  logic      gpu_clk;
  logic      rst_in;
  logic      cmd_valid;
  logic      cmd_ready;
  rect_cmd_t cmd_data;
  logic      frame_start;
  logic      frame_end;
  logic      rd_en;
  coord_x_t  rd_x;
  coord_y_t  rd_y;
  logic      rd_valid;
  rgb_t      rd_rgb;
  logic      busy;
  count_t    frame_count;
  count_t    last_pixel_count;

  // one entry per pattern line, six hex fields each
  byte         ops[$];
  int          vals[$];
  logic [31:0] lfsr = 32'h98b;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  int          frames_done = 0;

  gpu_top dut0 (.*);

  initial gpu_clk = 1'b0;
  always #50 gpu_clk = ~gpu_clk;

  always @(posedge gpu_clk) cycles <= cycles + 1;

  initial begin
    wait (cycle_limit > 0);
    wait (cycles >= cycle_limit);
    $display("timeout: DUT did not finish within %0d cycles", cycle_limit);
    $display("errors: %0d", errors + 1);
    $display("** FAIL **");
    $finish;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    // taps 32 22 2 1
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    assert (got == exp) else begin
      errors++;
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic wait_random_gap();
    int n;
    n = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      n = (n << 1) | int'(lfsr[0]);
    end
    repeat (n) @(posedge gpu_clk);
  endtask

  task automatic push_rect(input rect_cmd_t c);
    wait_random_gap();
    @(posedge gpu_clk);
    cmd_valid <= 1'b1;
    cmd_data  <= c;
    // ready seen here is what the next rising edge samples
    @(negedge gpu_clk);
    while (!cmd_ready) @(negedge gpu_clk);
    @(posedge gpu_clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic open_frame(input bit stray_start);
    @(posedge gpu_clk);
    frame_start <= 1'b1;
    @(posedge gpu_clk);
    frame_start <= 1'b0;
    @(negedge gpu_clk);
    check_value("busy after frame_start", busy, 1);
    if (stray_start) begin
      // should be ignored, the clear is still running
      @(posedge gpu_clk);
      frame_start <= 1'b1;
      @(posedge gpu_clk);
      frame_start <= 1'b0;
    end
  endtask

  task automatic close_frame(input int exp_pixels);
    @(posedge gpu_clk);
    frame_end <= 1'b1;
    @(posedge gpu_clk);
    frame_end <= 1'b0;
    @(negedge gpu_clk);
    while (busy) @(negedge gpu_clk);
    frames_done++;
    check_value("last_pixel_count", last_pixel_count, exp_pixels);
    check_value("frame_count", frame_count, frames_done);
  endtask

  task automatic read_pixel(input int x, input int y, input int exp_rgb);
    @(posedge gpu_clk);
    rd_en <= 1'b1;
    rd_x  <= coord_x_t'(x);
    rd_y  <= coord_y_t'(y);
    @(posedge gpu_clk);
    rd_en <= 1'b0;
    @(negedge gpu_clk);
    // no frame may open again without a frame_start of its own
    check_value("busy during readback", busy, 0);
    check_value("rd_valid", rd_valid, 1);
    check_value($sformatf("rd_rgb at (%0d,%0d)", x, y), rd_rgb, exp_rgb);
  endtask

  initial begin
    int    fd;
    int    budget;
    int    a[6];
    string line;
    budget = 0;
    rst_in      = 1'b1;
    cmd_valid   = 1'b0;
    cmd_data    = '0;
    frame_start = 1'b0;
    frame_end   = 1'b0;
    rd_en       = 1'b0;
    rd_x        = '0;
    rd_y        = '0;

    fd = $fopen("sim/gpu_patterns.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("cannot open the pattern file sim/gpu_patterns.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() >= 2 && line.getc(0) != "#") begin
          a = '{default: 0};
          void'($sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h %h",
                        a[0], a[1], a[2], a[3], a[4], a[5]));
          ops.push_back(line.getc(0));
          for (int k = 0; k < 6; k++) begin
            vals.push_back(a[k]);
          end
          // clear sweep per frame, load plus area per rectangle
          case (line.getc(0))
            "F": budget += `GPU_FB_PIXELS + 64;
            "R": begin
              budget += 16;
              if (a[2] >= a[0] && a[3] >= a[1]) begin
                budget += (a[2] - a[0] + 1) * (a[3] - a[1] + 1);
              end
            end
            default: budget += 8;
          endcase
        end
      end
      $fclose(fd);
    end
    cycle_limit = 2 * budget + 200;

    repeat (8) @(posedge gpu_clk);
    rst_in <= 1'b0;
    @(negedge gpu_clk);
    check_value("frame_count after reset", frame_count, 0);
    check_value("last_pixel_count after reset", last_pixel_count, 0);
    check_value("cmd_ready at reset release", cmd_ready, 0);
    @(negedge gpu_clk);
    check_value("cmd_ready after reset", cmd_ready, 1);

    for (int i = 0; i < ops.size(); i++) begin
      case (ops[i])
        "F": open_frame(vals[i*6] != 0);
        "R": push_rect({coord_x_t'(vals[i*6]), coord_y_t'(vals[i*6+1]),
                        coord_x_t'(vals[i*6+2]), coord_y_t'(vals[i*6+3]),
                        depth_t'(vals[i*6+4]), rgb_t'(vals[i*6+5])});
        "E": close_frame(vals[i*6]);
        "P": read_pixel(vals[i*6], vals[i*6+1], vals[i*6+2]);
        default: begin
          errors++;
          $display("pattern entry %0d has an unknown line type", i);
        end
      endcase
    end

    repeat (4) @(posedge gpu_clk);
    errors += dut0.gpu_asserts0.fail_count;
    $display("checks done, %0d frames, errors: %0d", frames_done, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== sim/gpu_patterns.txt ====
# F stray_start | R x0 y0 x1 y1 z rgb | E pixels | P x y rgb
# all fields hex, P lines read back after the frame has closed
F 0
E 0
P 00 00 000
P 1f 0f 000
P 05 07 000
F 0
R 0c 08 0f 0a 80 f00
E 0c
P 0c 08 f00
P 0f 0a f00
P 10 0a 000
P 0b 08 000
P 0c 0b 000
F 1
R 00 00 07 03 80 0f0
R 04 02 09 05 40 00f
R 08 00 0b 07 60 ff0
R 00 00 01 01 80 fff
R 0a 00 03 02 10 abc
E 50
P 00 00 0f0
P 03 01 0f0
P 05 03 00f
P 09 04 00f
P 0a 04 ff0
P 0b 07 ff0
P 0c 08 000
F 0
R 0a 00 03 02 10 abc
R 1e 0e 1f 0f 20 123
E 04
P 1f 0f 123
P 1e 0e 123
P 0a 00 000

// ==== all.f ====
+incdir+hdl
hdl/gpu_pkg.sv
hdl/rect_fifo.sv
hdl/rect_raster.sv
hdl/depth_framebuffer.sv
hdl/frame_sequencer.sv
hdl/gpu_top.sv
sim/gpu_asserts.sv
sim/gpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module gpu_tb -f all.f -o gpu_sim
./obj_dir/gpu_sim | tee sim.log

if grep -qxF '** PASS **' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
